// File: i650_opfetch.f
+incdir+source
source/i650_pkg.sv
source/i650_ifs.sv
source/digit_timing.sv
source/op_reg.sv
source/op_decode.sv
source/op_issue.sv
source/op_fetch_top.sv
tests/tb_op_fetch.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f i650_opfetch.f --top-module tb_op_fetch -o tb_op_fetch \
   && ./obj_dir/tb_op_fetch | grep "Result: PASSED" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: source/digit_timing.sv
`timescale 1ns/10ps
`include "i650_params.svh"

module digit_timing (
   input logic         cp,
   input logic         op_reg_reset,
   digit_timing_if.ring timing
);

   localparam int CNT_W = $clog2(`I650_DIGIT_TIMES);
   localparam logic [CNT_W-1:0] DIGIT_LAST = CNT_W'(`I650_DIGIT_TIMES - 1);

   logic [CNT_W-1:0] digit_cnt;
   logic [CNT_W-1:0] digit_next;

   // Ring wraps from d10 back to d0
   assign digit_next = (digit_cnt == DIGIT_LAST) ? '0 : digit_cnt + 1'b1;

   //////////////////////////////////////////////////
   // Counter and single-digit strobes
   //////////////////////////////////////////////////

   // Strobes are decoded from the next count so they line up with digit_cnt
   always_ff @(posedge cp) begin
      if (op_reg_reset) begin
         digit_cnt  <= '0;
         timing.d0  <= 1'b1;
         timing.d9  <= 1'b0;
         timing.d10 <= 1'b0;
      end else begin
         digit_cnt  <= digit_next;
         timing.d0  <= (digit_next == '0);
         timing.d9  <= (digit_next == CNT_W'(9));
         timing.d10 <= (digit_next == DIGIT_LAST);
      end
   end

   // Range gates come straight off the count
   // d1_d5 covers d1 up to d5, d5_dx runs from d5 to the end of the word
   assign timing.d1_d5 = (digit_cnt >= CNT_W'(1)) && (digit_cnt <= CNT_W'(5));
   assign timing.d5_dx = (digit_cnt >= CNT_W'(5));

endmodule

// File: source/i650_ifs.sv
`timescale 1ns/10ps

// Digit time strobes from the timing ring
// d1_d5 and d5_dx are ranges, the rest single digit times
interface digit_timing_if;
   logic d0;
   logic d9;
   logic d10;
   logic d1_d5;
   logic d5_dx;

   modport ring (output d0, d9, d10, d1_d5, d5_dx);
   modport user (input d0, d9, d10, d1_d5, d5_dx);
endinterface

// Op-code digits and their decoded form
interface op_word_if;
   import i650_pkg::*;

   biq_t     opreg_t;
   biq_t     opreg_u;
   logic     word_loaded;
   op_code_e op_code;
   logic     digits_valid;

   // Register side holds the digits, decoder looks at them
   modport reg_side (output opreg_t, opreg_u, word_loaded);
   modport decode_side (input opreg_t, opreg_u, output op_code, digits_valid);
   // Issue side only sees the finished operation
   modport issue_side (input word_loaded, op_code, digits_valid);
endinterface

// File: source/i650_params.svh
`ifndef I650_PARAMS_SVH
`define I650_PARAMS_SVH

// Digit times in one word, d0 through d10
`define I650_DIGIT_TIMES 11

// Credits held by the issue stage after reset
// Matches the number of buffer slots at the execution side
`define OP_CREDITS 2

// Entries in the issue queue between the op register and the consumer
`define OP_QUEUE_DEPTH 2

`endif

// File: source/i650_pkg.sv
package i650_pkg;

   //////////////////////////////////////////////////
   // Bi-quinary digit
   //////////////////////////////////////////////////

   // Bit order is b5, b0, q4, q3, q2, q1, q0
   // A legal digit has one bi bit and one quinary bit set
   typedef logic [0:6] biq_t;

   // No bits lit, as read from an empty pedestal
   localparam biq_t biq_blank = 7'b0000000;

   //////////////////////////////////////////////////
   // Operation codes
   //////////////////////////////////////////////////

   // Each value is the two-digit op-code number itself
   // INVALID sits above the largest two-digit number
   typedef enum logic [6:0] {
      NO_OP   = 7'd0,
      STOP    = 7'd1,
      AU      = 7'd10,
      SU      = 7'd11,
      STL     = 7'd20,
      STU     = 7'd21,
      STD     = 7'd24,
      BRNZU   = 7'd44,
      RAU     = 7'd60,
      RSU     = 7'd61,
      LD      = 7'd69,
      INVALID = 7'd127
   } op_code_e;

   // Issue stage FSM
   // SEND means op_valid is presented in the current cycle
   typedef enum logic {
      IDLE,
      SEND
   } issue_state_e;

endpackage

// File: source/op_decode.sv
`timescale 1ns/10ps

module op_decode (
   op_word_if.decode_side word
);

   import i650_pkg::*;

   logic       tens_ok;
   logic       units_ok;
   logic [3:0] tens_val;
   logic [3:0] units_val;
   logic [6:0] op_num;
   op_code_e   named_code;

   //////////////////////////////////////////////////
   // Digit checks
   //////////////////////////////////////////////////

   // Exactly one bi bit and one quinary bit
   // A blank digit fails both halves of the check
   function automatic logic biq_ok(input biq_t d);
      logic bi_one;
      logic q_one;
      bi_one = d[0] ^ d[1];
      q_one  = ($countones(d[2:6]) == 1);
      return bi_one && q_one;
   endfunction

   // Quinary position plus five when b5 is lit
   // Only meaningful for a digit that passed biq_ok
   function automatic logic [3:0] biq_value(input biq_t d);
      logic [3:0] q;
      if (d[2])
         q = 4'd4;
      else if (d[3])
         q = 4'd3;
      else if (d[4])
         q = 4'd2;
      else if (d[5])
         q = 4'd1;
      else
         q = 4'd0;
      return d[0] ? q + 4'd5 : q;
   endfunction

   assign tens_ok   = biq_ok(word.opreg_t);
   assign units_ok  = biq_ok(word.opreg_u);
   assign tens_val  = biq_value(word.opreg_t);
   assign units_val = biq_value(word.opreg_u);

   // Two-digit number, at most 99
   assign op_num = 7'(tens_val) * 7'd10 + 7'(units_val);

   //////////////////////////////////////////////////
   // Operation lookup
   //////////////////////////////////////////////////

   always_comb begin
      case (op_num)
         7'd0:    named_code = NO_OP;
         7'd1:    named_code = STOP;
         7'd10:   named_code = AU;
         7'd11:   named_code = SU;
         7'd20:   named_code = STL;
         7'd21:   named_code = STU;
         7'd24:   named_code = STD;
         7'd44:   named_code = BRNZU;
         7'd60:   named_code = RAU;
         7'd61:   named_code = RSU;
         7'd69:   named_code = LD;
         default: named_code = INVALID;
      endcase
   end

   // Malformed digits override whatever the lookup found
   assign word.digits_valid = tens_ok & units_ok;
   assign word.op_code      = word.digits_valid ? named_code : INVALID;

endmodule

// File: source/op_fetch_top.sv
`timescale 1ns/10ps

module op_fetch_top (
   input logic                cp,
   input logic                op_reg_reset,
   input logic                restart_a,
   input logic                restart_b,
   input logic                d_alt,
   input logic                i_alt,
   input logic                tlu_band_change,
   input logic                man_prog_reset,
   input i650_pkg::biq_t      prog_step_ped,
   input logic                credit_return,
   output logic               ri_addr_reg,
   output logic               op_valid,
   output i650_pkg::op_code_e op_code,
   output i650_pkg::biq_t     opreg_t,
   output i650_pkg::biq_t     opreg_u,
   output logic               overrun
);

   digit_timing_if timing_if ();
   op_word_if      word_if ();

   //////////////////////////////////////////////////
   // Fetch path: ring, register, decode, issue
   //////////////////////////////////////////////////

   digit_timing u_timing (
      .cp           (cp),
      .op_reg_reset (op_reg_reset),
      .timing       (timing_if)
   );

   op_reg u_op_reg (
      .cp              (cp),
      .op_reg_reset    (op_reg_reset),
      .restart_a       (restart_a),
      .restart_b       (restart_b),
      .d_alt           (d_alt),
      .i_alt           (i_alt),
      .tlu_band_change (tlu_band_change),
      .man_prog_reset  (man_prog_reset),
      .prog_step_ped   (prog_step_ped),
      .ri_addr_reg     (ri_addr_reg),
      .timing          (timing_if),
      .word            (word_if)
   );

   // Purely combinational, sits between the register and the queue
   op_decode u_decode (
      .word (word_if)
   );

   op_issue u_issue (
      .cp            (cp),
      .op_reg_reset  (op_reg_reset),
      .credit_return (credit_return),
      .word          (word_if),
      .op_valid      (op_valid),
      .op_code       (op_code),
      .overrun       (overrun)
   );

   // Digit registers are visible for the console side
   assign opreg_t = word_if.opreg_t;
   assign opreg_u = word_if.opreg_u;

endmodule

// File: source/op_issue.sv
`timescale 1ns/10ps
`include "i650_params.svh"

module op_issue (
   input logic              cp,
   input logic              op_reg_reset,
   input logic              credit_return,
   op_word_if.issue_side    word,
   output logic             op_valid,
   output i650_pkg::op_code_e op_code,
   output logic             overrun
);

   import i650_pkg::*;

   localparam int PTR_W = (`OP_QUEUE_DEPTH > 1) ? $clog2(`OP_QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(`OP_QUEUE_DEPTH + 1);
   localparam int CRD_W = $clog2(`OP_CREDITS + 1);
   localparam logic [PTR_W-1:0] PTR_LAST   = PTR_W'(`OP_QUEUE_DEPTH - 1);
   localparam logic [CNT_W-1:0] QUEUE_FULL = CNT_W'(`OP_QUEUE_DEPTH);
   localparam logic [CRD_W-1:0] CREDIT_MAX = CRD_W'(`OP_CREDITS);

   op_code_e         q_mem [`OP_QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] q_count;
   logic [CRD_W-1:0] credits;
   logic             full;
   logic             push;
   logic             pop;
   logic             give;
   issue_state_e     state;
   issue_state_e     state_next;

   //////////////////////////////////////////////////
   // Queue
   //////////////////////////////////////////////////

   assign full = (q_count == QUEUE_FULL);
   assign push = word.word_loaded & ~full;
   // An entry leaves only when the consumer has room for it
   assign pop  = (q_count != '0) && (credits != '0);

   // Malformed words arrive already tagged INVALID by the decoder
   always_ff @(posedge cp) begin
      if (push)
         q_mem[wr_ptr] <= word.op_code;
      if (pop)
         op_code <= q_mem[rd_ptr];
   end

   always_ff @(posedge cp) begin
      if (op_reg_reset) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         q_count <= '0;
         overrun <= 1'b0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
         q_count <= q_count + CNT_W'(push) - CNT_W'(pop);
         // Sticky until reset because a dropped word is never recovered
         if (word.word_loaded && full)
            overrun <= 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Credits and issue FSM
   //////////////////////////////////////////////////

   // A return at full credit has nowhere to go unless one is spent now
   assign give = credit_return & (pop | (credits != CREDIT_MAX));

   always_ff @(posedge cp) begin
      if (op_reg_reset)
         credits <= CREDIT_MAX;
      else if (pop && !give)
         credits <= credits - 1'b1;
      else if (give && !pop)
         credits <= credits + 1'b1;
   end

   // The entry popped in this cycle is presented in the next one
   assign state_next = pop ? SEND : IDLE;

   always_ff @(posedge cp) begin
      if (op_reg_reset)
         state <= IDLE;
      else
         state <= state_next;
   end

   assign op_valid = (state == SEND);

endmodule

// File: source/op_reg.sv
`timescale 1ns/10ps

module op_reg (
   input logic             cp,
   input logic             op_reg_reset,
   input logic             restart_a,
   input logic             restart_b,
   input logic             d_alt,
   input logic             i_alt,
   input logic             tlu_band_change,
   input logic             man_prog_reset,
   input i650_pkg::biq_t   prog_step_ped,
   output logic            ri_addr_reg,
   digit_timing_if.user    timing,
   op_word_if.reg_side     word
);

   import i650_pkg::*;

   logic op_clear;
   logic tens_load;

   //////////////////////////////////////////////////
   // Enable and clear conditions
   //////////////////////////////////////////////////

   // Data alteration opens the gate for the second half of the word
   // Instruction alteration and band change use d1 to d5 instead
   assign ri_addr_reg = (d_alt & restart_b & timing.d5_dx)
                      | (i_alt & restart_b & timing.d1_d5)
                      | (tlu_band_change & timing.d1_d5);

   // Band change only clears at the start of a word
   assign op_clear = man_prog_reset | restart_a | (tlu_band_change & timing.d0);

   // Tens digit arrives last, so its load completes the op code
   assign tens_load = ri_addr_reg & timing.d10 & ~op_clear;

   //////////////////////////////////////////////////
   // Digit registers
   //////////////////////////////////////////////////

   // The pedestal is sampled on the clock edge that ends the digit time
   always_ff @(posedge cp) begin
      if (op_reg_reset || op_clear) begin
         word.opreg_t <= biq_blank;
         word.opreg_u <= biq_blank;
      end else if (ri_addr_reg) begin
         // Units come in at d9
         if (timing.d9)
            word.opreg_u <= prog_step_ped;
         if (timing.d10)
            word.opreg_t <= prog_step_ped;
      end
   end

   // One-cycle strobe after the tens digit is in place
   always_ff @(posedge cp) begin
      if (op_reg_reset)
         word.word_loaded <= 1'b0;
      else
         word.word_loaded <= tens_load;
   end

endmodule

// File: tests/tb_op_fetch.sv
`timescale 1ns/10ps
`include "i650_params.svh"

module tb_op_fetch;

   import i650_pkg::*;

   // Words presented over all tests, which sets the watchdog budget
   localparam int N_WORDS = 52;

   logic     cp;
   logic     op_reg_reset;
   logic     restart_a;
   logic     restart_b;
   logic     d_alt;
   logic     i_alt;
   logic     tlu_band_change;
   logic     man_prog_reset;
   biq_t     prog_step_ped;
   logic     credit_return;
   logic     ri_addr_reg;
   logic     op_valid;
   op_code_e op_code;
   biq_t     opreg_t;
   biq_t     opreg_u;
   logic     overrun;

   int    tb_digit = 0;
   int    issued = 0;
   int    returned = 0;
   int    errors = 0;
   int    base;
   int    exp_q[$];
   string test_name = "reset";
   biq_t  wt;
   biq_t  wu;

   op_fetch_top dut0 (.*);

   initial begin
      cp = 1'b0;
      forever #2 cp = ~cp;
   end

   // Own model of the digit ring that starts at d0 after reset
   always @(posedge cp) begin
      if (op_reg_reset || tb_digit == `I650_DIGIT_TIMES - 1)
         tb_digit <= 0;
      else
         tb_digit <= tb_digit + 1;
   end

   //////////////////////////////////////////////////
   // Reference model and checking
   //////////////////////////////////////////////////

   task automatic abort_run(string what);
      errors++;
      $display("%s", what);
      $display("Result: FAILED");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_value(string what, int exp, int act);
      if (exp !== act) begin
         $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
         abort_run("value mismatch");
      end
   endtask

   // Digit value or -1 when the bi or quinary half is not one-hot
   function automatic int digit_val(biq_t d);
      logic [4:0] qv;
      int         pos;
      qv = d[2:6];
      case (qv)
         5'b00001: pos = 0;
         5'b00010: pos = 1;
         5'b00100: pos = 2;
         5'b01000: pos = 3;
         5'b10000: pos = 4;
         default:  pos = -1;
      endcase
      if (pos < 0 || d[0] == d[1])
         return -1;
      return d[0] ? pos + 5 : pos;
   endfunction

   function automatic int ref_op(biq_t t, biq_t u);
      int tv;
      int uv;
      tv = digit_val(t);
      uv = digit_val(u);
      if (tv < 0 || uv < 0)
         return 127;
      case (tv * 10 + uv)
         0, 1, 10, 11, 20, 21, 24, 44, 60, 61, 69: return tv * 10 + uv;
         default: return 127;
      endcase
   endfunction

   function automatic biq_t enc_digit(int v);
      return (v >= 5 ? 7'b1000000 : 7'b0100000) | (7'd1 << (v % 5));
   endfunction

   // Address register gate opens for the second half under D alteration and for d1 to d5 otherwise
   function automatic int expect_ri();
      logic late;
      logic early;
      late  = (tb_digit >= 5);
      early = (tb_digit >= 1) && (tb_digit <= 5);
      return int'((d_alt & restart_b & late) | (i_alt & restart_b & early)
                  | (tlu_band_change & early));
   endfunction

   // Outputs are sampled in the middle of the low phase away from both clock edges
   always @(negedge cp) begin
      #1;
      if (!op_reg_reset) begin
         check_value("ri_addr_reg", expect_ri(), int'(ri_addr_reg));
         if (op_valid) begin
            issued++;
            if (exp_q.size() == 0)
               abort_run("op_valid raised with no operation outstanding");
            else if (issued > `OP_CREDITS + returned)
               abort_run("op_valid raised while no credit was left");
            else
               check_value("op_code", exp_q.pop_front(), int'(op_code));
         end
      end
   end

   always @(posedge cp) begin
      if (!op_reg_reset && credit_return)
         returned <= returned + 1;
   end

   initial begin
      repeat (N_WORDS * 11 + 200) @(posedge cp);
      abort_run("watchdog expired before the tests finished");
   end

   //////////////////////////////////////////////////
   // Stimulus tasks
   //////////////////////////////////////////////////

   // Units go in at d9 and tens at d10 and the task returns at d0 of the next word
   task automatic present_word(biq_t t, biq_t u, logic en);
      do @(negedge cp); while (tb_digit != 9);
      d_alt = en;
      prog_step_ped = u;
      @(negedge cp);
      prog_step_ped = t;
      @(negedge cp);
      d_alt = 1'b0;
      prog_step_ped = biq_blank;
   endtask

   task automatic load_word(biq_t t, biq_t u);
      present_word(t, u, 1'b1);
      exp_q.push_back(ref_op(t, u));
      check_value("opreg_t", int'(t), int'(opreg_t));
      check_value("opreg_u", int'(u), int'(opreg_u));
   endtask

   task automatic give_credit();
      credit_return = 1'b1;
      @(negedge cp);
      credit_return = 1'b0;
   endtask

   task automatic wait_issue();
      do @(negedge cp); while (!op_valid);
   endtask

   // With an empty queue and full credits op_valid lands two edges after d10
   task automatic load_and_issue(biq_t t, biq_t u);
      load_word(t, u);
      check_value("op_valid one cycle after load", 0, int'(op_valid));
      @(negedge cp);
      check_value("op_valid at the push edge", 0, int'(op_valid));
      @(negedge cp);
      check_value("op_valid two cycles after load", 1, int'(op_valid));
      give_credit();
   endtask

   // Named codes, other legal numbers and raw bit patterns in equal parts
   task automatic gen_word(output biq_t t, output biq_t u);
      int kind;
      kind = int'($urandom % 3);
      if (kind == 0) begin
         t = enc_digit(int'($urandom % 7));
         u = enc_digit((t == enc_digit(4)) ? 4 : int'($urandom % 2));
      end else if (kind == 1) begin
         t = enc_digit(int'($urandom % 10));
         u = enc_digit(int'($urandom % 10));
      end else begin
         t = 7'($urandom);
         u = 7'($urandom);
      end
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      void'($urandom(32'hbbbb));
      op_reg_reset    = 1'b1;
      restart_a       = 1'b0;
      restart_b       = 1'b0;
      d_alt           = 1'b0;
      i_alt           = 1'b0;
      tlu_band_change = 1'b0;
      man_prog_reset  = 1'b0;
      prog_step_ped   = biq_blank;
      credit_return   = 1'b0;
      repeat (4) @(posedge cp);
      @(negedge cp);
      op_reg_reset = 1'b0;
      check_value("opreg_t", int'(biq_blank), int'(opreg_t));
      check_value("opreg_u", int'(biq_blank), int'(opreg_u));
      check_value("op_valid", 0, int'(op_valid));
      check_value("overrun", 0, int'(overrun));
      restart_b = 1'b1;

      // An enabled load followed by a word with the gate shut must leave AU in place
      test_name = "load_enable";
      load_and_issue(enc_digit(1), enc_digit(0));
      present_word(enc_digit(6), enc_digit(9), 1'b0);
      check_value("opreg_t held", int'(enc_digit(1)), int'(opreg_t));
      check_value("opreg_u held", int'(enc_digit(0)), int'(opreg_u));
      repeat (22) begin
         @(negedge cp);
         i_alt = 1'($urandom);
         restart_b = 1'($urandom);
      end
      i_alt = 1'b0;
      restart_b = 1'b1;

      test_name = "clear";
      @(negedge cp);
      man_prog_reset = 1'b1;
      @(negedge cp);
      man_prog_reset = 1'b0;
      check_value("opreg_t after prog reset", int'(biq_blank), int'(opreg_t));
      check_value("opreg_u after prog reset", int'(biq_blank), int'(opreg_u));
      load_and_issue(enc_digit(2), enc_digit(4));
      @(negedge cp);
      restart_a = 1'b1;
      @(negedge cp);
      restart_a = 1'b0;
      check_value("opreg_t after restart A", int'(biq_blank), int'(opreg_t));
      check_value("opreg_u after restart A", int'(biq_blank), int'(opreg_u));
      load_and_issue(enc_digit(6), enc_digit(9));
      do @(negedge cp); while (tb_digit != 0);
      tlu_band_change = 1'b1;
      @(negedge cp);
      tlu_band_change = 1'b0;
      check_value("opreg_t after band change", int'(biq_blank), int'(opreg_t));
      check_value("opreg_u after band change", int'(biq_blank), int'(opreg_u));

      test_name = "decode";
      repeat (40) begin
         gen_word(wt, wu);
         load_and_issue(wt, wu);
      end

      // Two words use up the credits and the next two wait in the queue
      test_name = "credit_flow";
      base = issued;
      repeat (4) begin
         gen_word(wt, wu);
         load_word(wt, wu);
      end
      repeat (11) @(negedge cp);
      check_value("issued without returns", 2, issued - base);
      repeat (2) begin
         give_credit();
         wait_issue();
      end

      // With no credits left words three and four find the queue full
      test_name = "overrun";
      load_word(enc_digit(2), enc_digit(0));
      load_word(enc_digit(2), enc_digit(1));
      check_value("overrun before drop", 0, int'(overrun));
      present_word(enc_digit(6), enc_digit(0), 1'b1);
      @(negedge cp);
      check_value("overrun after drop", 1, int'(overrun));
      present_word(enc_digit(6), enc_digit(1), 1'b1);
      repeat (2) begin
         give_credit();
         wait_issue();
      end
      give_credit();
      repeat (22) @(negedge cp);
      check_value("overrun sticky", 1, int'(overrun));

      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule
